//--- vlog.f
soc_bus_pkg.sv
soc_map_pkg.sv
boot_rom.sv
sram.sv
clint_timer.sv
bus_ctrl.sv
soc_top.sv
tb_soc.sv

//--- Makefile
# Verilator build and run of the SoC bus testbench

TOP := tb_soc
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f vlog.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -x -F '** PASS **' $(LOG)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir $(LOG)

//--- tb_soc.sv
`timescale 1ns/100ps
/*
 * Testbench for the SoC bus: ROM, SRAM, error regions, back-pressure
 * and the CLINT timer, checked against a reference model
 */
module tb_soc;
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int ResetCycles = 5;
  localparam int RtcHalf     = 8;
  localparam int TimerBound  = 3 * 2 * RtcHalf + 8;
  localparam int NumRom      = 8;
  localparam int NumSram     = 8;
  localparam int NumStall    = 12;
  // timer 5, rom NumRom+2, sram 3*NumSram, errors 8, back-pressure NumStall
  localparam int NumTxn      = 5 + NumRom + 2 + 3 * NumSram + 8 + NumStall;
  localparam int WatchdogCycles = ResetCycles + NumTxn * 40 + TimerBound;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  logic     rtc_i = 1'b0;
  logic     req_valid_i;
  bus_req_t req_i;
  logic     req_ready_o;
  logic     rsp_valid_o;
  bus_rsp_t rsp_o;
  logic     rsp_ready_i;
  logic     timer_irq_o;

  bus_rsp_t    exp_q [$];
  logic [65:0] mask_q [$];
  string       name_q [$];
  bus_rsp_t    last_rsp;
  data_t       shadow [SramWords] = '{default: '0};
  int          sram_idx [NumSram];
  logic [31:0] lfsr_q = 32'hc75;
  int          n_checks = 0;
  int          n_errors = 0;
  int          chk_mark = 0;
  int          err_mark = 0;

  soc_top dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .req_ready_o ( req_ready_o ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .rsp_ready_i ( rsp_ready_i ),
    .timer_irq_o ( timer_irq_o )
  );

  always #50 clk_i = ~clk_i;

  // Slow real-time clock of 16 core cycles per period
  always begin
    repeat (RtcHalf) @(negedge clk_i);
    rtc_i = ~rtc_i;
  end

  // ----------------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------------
  // Fibonacci LFSR over x^32 + x^22 + x^2 + x + 1
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic bus_req_t make_req(bus_op_e op, addr_t addr, data_t wdata, strb_t be);
    bus_req_t req;
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    req.be    = be;
    return req;
  endfunction

  function automatic addr_t word_addr(addr_t base, int idx);
    return base + 32'(idx * 8);
  endfunction

  // Expected response from the address map, ROM rule and shadow SRAM
  function automatic bus_rsp_t ref_access(input bus_req_t req);
    bus_rsp_t    rsp;
    logic [31:0] widx;
    rsp = '0;
    if (req.addr >= RomBase && req.addr < RomBase + RomLength) begin
      widx = (req.addr - RomBase) >> 3;
      if (req.op == OP_WRITE) begin
        rsp.status = RESP_SLVERR;
      end else begin
        rsp.rdata = {widx, RomTag ^ widx};
      end
    end else if (req.addr >= ClintBase && req.addr < ClintBase + ClintLength) begin
      // Timer values are judged by the timer test itself
      rsp.status = RESP_OKAY;
    end else if (req.addr >= SramBase && req.addr < SramBase + SramLength) begin
      widx = (req.addr - SramBase) >> 3;
      if (req.op == OP_WRITE) begin
        for (int b = 0; b < 8; b++) begin
          if (req.be[b]) begin
            shadow[widx[SramIdxW-1:0]][8*b +: 8] = req.wdata[8*b +: 8];
          end
        end
      end else begin
        rsp.rdata = shadow[widx[SramIdxW-1:0]];
      end
    end else if (req.addr >= GpioBase && req.addr < GpioBase + GpioLength) begin
      rsp.status = RESP_SLVERR;
    end else begin
      rsp.status = RESP_DECERR;
    end
    return rsp;
  endfunction

  task automatic check(input string name, input logic [65:0] expected,
                       input logic [65:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s: checks %0d, errors %0d", name, n_checks - chk_mark, n_errors - err_mark);
    chk_mark = n_checks;
    err_mark = n_errors;
  endtask

  // One transaction with latency, hold and ready checks; stall delays rsp_ready_i
  task automatic run_access(input bus_req_t req, input string name, input int stall,
                            input logic check_data);
    bus_rsp_t held;
    int       lat;
    exp_q.push_back(ref_access(req));
    mask_q.push_back(check_data ? '1 : {2'b11, 64'h0});
    name_q.push_back(name);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i       = req;
    rsp_ready_i = (stall == 0);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    // Accepted on the coming rising edge
    @(negedge clk_i);
    req_valid_i = 1'b0;
    lat = 1;
    while (!rsp_valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    check({name, " latency"}, 66'd2, 66'(lat));
    held = rsp_o;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk_i);
      check({name, " hold"}, held, rsp_o);
      check({name, " busy"}, 66'd0, 66'(req_ready_o));
    end
    rsp_ready_i = 1'b1;
    @(negedge clk_i);
    check({name, " ready"}, 66'd1, 66'(req_ready_o));
  endtask

  // ----------------------------------------------------------------------------
  // Response compare
  // ----------------------------------------------------------------------------
  initial begin : compare
    forever begin
      @(posedge clk_i);
      if (rst_ni && rsp_valid_o && rsp_ready_i) begin
        last_rsp = rsp_o;
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("A response arrived with no request outstanding");
        end else begin
          check(name_q.pop_front(), exp_q.pop_front(), rsp_o & mask_q.pop_front());
        end
      end
    end
  end

  // ----------------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------------
  task automatic test_timer();
    data_t m1;
    data_t m2;
    int    waited;
    check("timer irq after reset", 66'd0, 66'(timer_irq_o));
    run_access(make_req(OP_READ, ClintBase + MtimeOffset, '0, '1), "mtime read 1", 0, 1'b0);
    m1 = last_rsp.rdata;
    repeat (20) @(negedge clk_i);
    run_access(make_req(OP_READ, ClintBase + MtimeOffset, '0, '1), "mtime read 2", 0, 1'b0);
    m2 = last_rsp.rdata;
    check("mtime order", 66'd1, 66'(m2 >= m1));
    run_access(make_req(OP_WRITE, ClintBase + MtimecmpOffset, m2 + 64'd3, '1),
               "mtimecmp set", 0, 1'b1);
    waited = 0;
    while (!timer_irq_o && waited < TimerBound) begin
      @(negedge clk_i);
      waited++;
    end
    check("timer irq rise", 66'd1, 66'(timer_irq_o));
    run_access(make_req(OP_READ, ClintBase + MtimeOffset, '0, '1), "mtime at irq", 0, 1'b0);
    check("mtime past compare", 66'd1, 66'(last_rsp.rdata >= m2 + 64'd3));
    run_access(make_req(OP_WRITE, ClintBase + MtimecmpOffset, '1, '1),
               "mtimecmp clear", 0, 1'b1);
    repeat (2) @(negedge clk_i);
    check("timer irq drop", 66'd0, 66'(timer_irq_o));
    report_test("timer");
  endtask

  task automatic test_rom();
    int w;
    for (int i = 0; i < NumRom; i++) begin
      w = int'(rand_bits(6));
      run_access(make_req(OP_READ, word_addr(RomBase, w), '0, '1),
                 $sformatf("rom read %0d", w), 0, 1'b1);
    end
    w = int'(rand_bits(6));
    run_access(make_req(OP_WRITE, word_addr(RomBase, w), rand_bits(64), '1),
               "rom write", 0, 1'b1);
    run_access(make_req(OP_READ, word_addr(RomBase, w), '0, '1), "rom reread", 0, 1'b1);
    report_test("rom_reads");
  endtask

  task automatic test_sram();
    // Full-word writes first, so no word holds unknown bytes
    for (int i = 0; i < NumSram; i++) begin
      sram_idx[i] = i * 32 + int'(rand_bits(5));
      run_access(make_req(OP_WRITE, word_addr(SramBase, sram_idx[i]), rand_bits(64), '1),
                 $sformatf("sram fill %0d", sram_idx[i]), 0, 1'b1);
    end
    for (int i = 0; i < NumSram; i++) begin
      run_access(make_req(OP_WRITE, word_addr(SramBase, sram_idx[i]), rand_bits(64),
                          strb_t'(rand_bits(8))),
                 $sformatf("sram be write %0d", sram_idx[i]), 0, 1'b1);
    end
    for (int i = NumSram - 1; i >= 0; i--) begin
      run_access(make_req(OP_READ, word_addr(SramBase, sram_idx[i]), '0, '1),
                 $sformatf("sram read %0d", sram_idx[i]), 0, 1'b1);
    end
    report_test("sram_rw");
  endtask

  task automatic test_errors();
    addr_t a;
    for (int i = 0; i < 4; i++) begin
      a = word_addr(GpioBase, int'(rand_bits(9)));
      run_access(make_req((i % 2 == 0) ? OP_READ : OP_WRITE, a, rand_bits(64), '1),
                 $sformatf("gpio %h", a), 0, 1'b1);
    end
    run_access(make_req(OP_READ, RomBase + RomLength, '0, '1), "unmapped rom end", 0, 1'b1);
    run_access(make_req(OP_WRITE, SramBase + SramLength, rand_bits(64), '1),
               "unmapped sram end", 0, 1'b1);
    run_access(make_req(OP_READ, 32'h0, '0, '1), "unmapped zero", 0, 1'b1);
    a = word_addr(32'h5000_0000, int'(rand_bits(24)));
    run_access(make_req(OP_WRITE, a, rand_bits(64), '1), "unmapped high", 0, 1'b1);
    report_test("error_regions");
  endtask

  task automatic test_backpressure();
    int stall;
    int k;
    for (int i = 0; i < NumStall; i++) begin
      stall = 1 + int'(rand_bits(3));
      k     = int'(rand_bits(3));
      if (i % 2 == 0) begin
        run_access(make_req(OP_READ, word_addr(SramBase, sram_idx[k]), '0, '1),
                   $sformatf("stall sram %0d", i), stall, 1'b1);
      end else begin
        run_access(make_req(OP_READ, word_addr(RomBase, k), '0, '1),
                   $sformatf("stall rom %0d", i), stall, 1'b1);
      end
    end
    report_test("backpressure");
  endtask

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_timer();
    test_rom();
    test_sram();
    test_errors();
    test_backpressure();
    repeat (2) @(negedge clk_i);
    if (exp_q.size() != 0) begin
      n_errors++;
      $display("%0d expected responses never arrived", exp_q.size());
    end
    $display("total: checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- soc_top.sv
`timescale 1ns/100ps
/*
 * SoC top: bus controller with boot ROM, SRAM and CLINT timer
 */
module soc_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rtc_i,
  input  logic                  req_valid_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output logic                  req_ready_o,
  output logic                  rsp_valid_o,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  input  logic                  rsp_ready_i,
  output logic                  timer_irq_o
);
  import soc_bus_pkg::*;

  dev_req_t dev_req;
  logic     rom_sel;
  logic     sram_sel;
  logic     clint_sel;
  data_t    rom_rdata;
  data_t    sram_rdata;
  data_t    clint_rdata;

  // ----------------------------------------------------------------------------
  // Controller
  // ----------------------------------------------------------------------------
  bus_ctrl u_ctrl (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .req_valid_i   ( req_valid_i ),
    .req_i         ( req_i       ),
    .req_ready_o   ( req_ready_o ),
    .rsp_valid_o   ( rsp_valid_o ),
    .rsp_o         ( rsp_o       ),
    .rsp_ready_i   ( rsp_ready_i ),
    .dev_req_o     ( dev_req     ),
    .rom_sel_o     ( rom_sel     ),
    .sram_sel_o    ( sram_sel    ),
    .clint_sel_o   ( clint_sel   ),
    .rom_rdata_i   ( rom_rdata   ),
    .sram_rdata_i  ( sram_rdata  ),
    .clint_rdata_i ( clint_rdata )
  );

  // ----------------------------------------------------------------------------
  // Devices
  // ----------------------------------------------------------------------------
  boot_rom u_rom (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .sel_i     ( rom_sel   ),
    .dev_req_i ( dev_req   ),
    .rdata_o   ( rom_rdata )
  );

  sram u_sram (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .sel_i     ( sram_sel   ),
    .dev_req_i ( dev_req    ),
    .rdata_o   ( sram_rdata )
  );

  // Timer interrupt goes straight out
  clint_timer u_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .sel_i       ( clint_sel   ),
    .dev_req_i   ( dev_req     ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o )
  );

endmodule

//--- bus_ctrl.sv
`timescale 1ns/100ps
/*
 * Bus controller: takes one request at a time, decodes its region,
 * strobes the target device and returns the response
 */
module bus_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output logic                  req_ready_o,
  output logic                  rsp_valid_o,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  input  logic                  rsp_ready_i,
  output soc_bus_pkg::dev_req_t dev_req_o,
  output logic                  rom_sel_o,
  output logic                  sram_sel_o,
  output logic                  clint_sel_o,
  input  soc_bus_pkg::data_t    rom_rdata_i,
  input  soc_bus_pkg::data_t    sram_rdata_i,
  input  soc_bus_pkg::data_t    clint_rdata_i
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_RESP} ctrl_state_e;

  ctrl_state_e state_q, state_d;
  logic        accept;
  region_e     region_q, region_d;
  offset_t     offset_d;
  dev_req_t    dev_q;
  bus_status_e status;

  function automatic logic in_range(addr_t addr, addr_t base, addr_t len);
    return (addr >= base) && (addr < base + len);
  endfunction

  // --------------------------------------------------------------------------
  // Handshake and region decode
  // --------------------------------------------------------------------------
  // Ready only while idle, so one request is in flight
  assign req_ready_o = (state_q == ST_IDLE);
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin
    region_d = REG_NONE;
    offset_d = '0;
    if (in_range(req_i.addr, RomBase, RomLength)) begin
      region_d = REG_ROM;
      offset_d = offset_t'(req_i.addr - RomBase);
    end else if (in_range(req_i.addr, ClintBase, ClintLength)) begin
      region_d = REG_CLINT;
      offset_d = offset_t'(req_i.addr - ClintBase);
    end else if (in_range(req_i.addr, SramBase, SramLength)) begin
      region_d = REG_SRAM;
      offset_d = offset_t'(req_i.addr - SramBase);
    end else if (in_range(req_i.addr, GpioBase, GpioLength)) begin
      region_d = REG_GPIO;
      offset_d = offset_t'(req_i.addr - GpioBase);
    end
  end

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_ACCESS;
        end
      end
      ST_ACCESS: state_d = ST_RESP;
      ST_RESP: begin
        if (rsp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request registered on accept and held until the next one
  always_ff @(posedge clk_i) begin
    if (accept) begin
      region_q     <= region_d;
      dev_q.we     <= (req_i.op == OP_WRITE);
      dev_q.offset <= offset_d;
      dev_q.wdata  <= req_i.wdata;
      dev_q.be     <= req_i.be;
    end
  end

  // --------------------------------------------------------------------------
  // Device strobes and response
  // --------------------------------------------------------------------------
  assign dev_req_o   = dev_q;
  assign rom_sel_o   = (state_q == ST_ACCESS) && (region_q == REG_ROM) && !dev_q.we;
  assign sram_sel_o  = (state_q == ST_ACCESS) && (region_q == REG_SRAM);
  assign clint_sel_o = (state_q == ST_ACCESS) && (region_q == REG_CLINT);

  always_comb begin
    case (region_q)
      REG_ROM:  status = dev_q.we ? RESP_SLVERR : RESP_OKAY;
      REG_GPIO: status = RESP_SLVERR;
      REG_NONE: status = RESP_DECERR;
      default:  status = RESP_OKAY;
    endcase
  end

  assign rsp_valid_o = (state_q == ST_RESP);

  always_comb begin
    rsp_o        = '0;
    rsp_o.status = status;
    // Only successful reads carry data
    if (status == RESP_OKAY && !dev_q.we) begin
      case (region_q)
        REG_ROM:   rsp_o.rdata = rom_rdata_i;
        REG_SRAM:  rsp_o.rdata = sram_rdata_i;
        REG_CLINT: rsp_o.rdata = clint_rdata_i;
        default:   rsp_o.rdata = '0;
      endcase
    end
  end

endmodule

//--- clint_timer.sv
`timescale 1ns/100ps
/*
 * CLINT timer: mtime counts real-time-clock edges, mtimecmp sets
 * the compare point, and the timer interrupt is raised at or past it
 */
module clint_timer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rtc_i,
  input  logic                  sel_i,
  input  soc_bus_pkg::dev_req_t dev_req_i,
  output soc_bus_pkg::data_t    rdata_o,
  output logic                  timer_irq_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [1:0] rtc_sync_q;
  logic       rtc_prev_q;
  logic       rtc_rise;
  logic       wr_en;
  logic       rd_en;
  data_t      mtime_q, mtime_d;
  data_t      mtimecmp_q, mtimecmp_d;
  data_t      rdata_q;
  logic       irq_q;

  // --------------------------------------------------------------------------
  // RTC synchronizer and edge detect
  // --------------------------------------------------------------------------
  assign rtc_rise = rtc_sync_q[1] && !rtc_prev_q;

  assign wr_en = sel_i && dev_req_i.we;
  assign rd_en = sel_i && !dev_req_i.we;

  // --------------------------------------------------------------------------
  // Register updates
  // --------------------------------------------------------------------------
  always_comb begin
    mtime_d    = mtime_q;
    mtimecmp_d = mtimecmp_q;
    if (rtc_rise) begin
      mtime_d = mtime_q + 64'd1;
    end
    // Bus write wins over a tick in the same cycle
    if (wr_en && dev_req_i.offset == MtimeOffset) begin
      mtime_d = apply_be(mtime_q, dev_req_i.wdata, dev_req_i.be);
    end
    if (wr_en && dev_req_i.offset == MtimecmpOffset) begin
      mtimecmp_d = apply_be(mtimecmp_q, dev_req_i.wdata, dev_req_i.be);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
      rdata_q    <= '0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= (mtime_q >= mtimecmp_q);
      if (rd_en) begin
        case (dev_req_i.offset)
          MtimeOffset:    rdata_q <= mtime_q;
          MtimecmpOffset: rdata_q <= mtimecmp_q;
          default:        rdata_q <= '0;
        endcase
      end
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = irq_q;

endmodule

//--- sram.sv
`timescale 1ns/100ps
/*
 * Word SRAM: single-port storage with byte-enable writes
 * and a registered read port
 */
module sram (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  sel_i,
  input  soc_bus_pkg::dev_req_t dev_req_i,
  output soc_bus_pkg::data_t    rdata_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  data_t               mem [SramWords];
  logic [SramIdxW-1:0] idx;
  logic                wr_en;
  logic                rd_en;
  data_t               rdata_q;

  assign idx   = dev_req_i.offset[SramIdxW+2:3];
  assign wr_en = sel_i && dev_req_i.we;
  assign rd_en = sel_i && !dev_req_i.we;

  // ----------------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[idx] <= apply_be(mem[idx], dev_req_i.wdata, dev_req_i.be);
    end
  end

  // ----------------------------------------------------------------------------
  // Read register
  // ----------------------------------------------------------------------------
  // Holds the last read word until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= mem[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- boot_rom.sv
`timescale 1ns/100ps
/*
 * Boot ROM: read-only word table with rule-generated contents
 */
module boot_rom (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  sel_i,
  input  soc_bus_pkg::dev_req_t dev_req_i,
  output soc_bus_pkg::data_t    rdata_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  data_t              rom_tbl [RomWords];
  logic [RomIdxW-1:0] idx;
  data_t              rdata_q;

  // Upper half is the word index, lower half the tagged index
  for (genvar i = 0; i < RomWords; i++) begin : gen_rom
    assign rom_tbl[i] = {32'(i), RomTag ^ 32'(i)};
  end

  // Byte offset to word index
  assign idx = dev_req_i.offset[RomIdxW+2:3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (sel_i) begin
      rdata_q <= rom_tbl[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- soc_map_pkg.sv
/*
 * Address map: region bases and lengths, device sizes,
 * boot ROM content rule and CLINT register offsets
 */
package soc_map_pkg;

  typedef enum logic [2:0] {
    REG_ROM,
    REG_CLINT,
    REG_SRAM,
    REG_GPIO,
    REG_NONE
  } region_e;

  // ------------------------------------------------------------------------
  // Region map
  // ------------------------------------------------------------------------
  localparam logic [31:0] RomBase     = 32'h0001_0000;
  localparam logic [31:0] RomLength   = 32'h0000_0200;

  localparam logic [31:0] ClintBase   = 32'h0200_0000;
  localparam logic [31:0] ClintLength = 32'h0001_0000;

  // Mapped but no device behind it
  localparam logic [31:0] GpioBase    = 32'h1000_0000;
  localparam logic [31:0] GpioLength  = 32'h0000_1000;

  localparam logic [31:0] SramBase    = 32'h8000_0000;
  localparam logic [31:0] SramLength  = 32'h0000_0800;

  // ------------------------------------------------------------------------
  // Device sizes in 64-bit words
  // ------------------------------------------------------------------------
  localparam int RomWords  = 64;
  localparam int SramWords = 256;
  localparam int RomIdxW   = $clog2(RomWords);
  localparam int SramIdxW  = $clog2(SramWords);

  // ROM word i holds {i, RomTag ^ i}
  localparam logic [31:0] RomTag = 32'hB007_C0DE;

  // CLINT register offsets within its region
  localparam logic [15:0] MtimecmpOffset = 16'h4000;
  localparam logic [15:0] MtimeOffset    = 16'hBFF8;

endpackage

//--- soc_bus_pkg.sv
/*
 * System bus types: data, address and strobe widths, opcodes,
 * response status and the request, response and device-access structs
 */
package soc_bus_pkg;

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 64;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned OffsetWidth = 16;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [StrbWidth-1:0]   strb_t;
  typedef logic [OffsetWidth-1:0] offset_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  // Encodings follow the usual AXI response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } bus_status_e;

  // ------------------------------------------------------------------------
  // Channel structs
  // ------------------------------------------------------------------------
  typedef struct packed {
    bus_op_e op;
    addr_t   addr;
    data_t   wdata;
    strb_t   be;
  } bus_req_t;

  typedef struct packed {
    bus_status_e status;
    data_t       rdata;
  } bus_rsp_t;

  // Shared by all devices, qualified by each device's own select
  typedef struct packed {
    logic    we;
    offset_t offset;
    data_t   wdata;
    strb_t   be;
  } dev_req_t;

  // Byte-enable merge of new data into an old word
  function automatic data_t apply_be(data_t old_word, data_t new_word, strb_t be);
    data_t res;
    res = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage
